//--- rtl/csr_pkg.sv
package csr_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // 12-bit csr address field
    typedef logic [11:0] csr_addr_t;

    // machine csrs
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MIP       = 12'h344;

    // counter low and high halves
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;

    // mstatus fields
    localparam int BIT_MIE    = 3;
    localparam int BIT_MPIE   = 7;
    // MPP occupies this bit and the one above
    localparam int BIT_MPP_LO = 11;

    // mie / mip fields
    localparam int BIT_MEIE   = 11;
    localparam int BIT_MEIP   = 11;

    typedef enum logic [3:0] {
        CSR_OP_NONE,
        CSR_OP_RW,
        CSR_OP_RS,
        CSR_OP_RC,
        CSR_OP_RWI,
        CSR_OP_RSI,
        CSR_OP_RCI,
        CSR_OP_MRET,
        CSR_OP_WFI
    } csr_op_e;

endpackage

//--- rtl/csr_decode.sv
`timescale 1ns/1ps

module csr_decode (
    input  csr_pkg::word_t     instr_i,
    input  logic               instr_valid_i,
    output csr_pkg::csr_op_e   op_o,
    output csr_pkg::csr_addr_t csr_addr_o,
    output logic               use_imm_o,
    output logic [4:0]         zimm_o,
    output logic               illegal_o
);

    localparam logic [6:0]     OPC_SYSTEM = 7'b1110011;
    localparam csr_pkg::word_t INSTR_MRET = 32'h3020_0073;
    localparam csr_pkg::word_t INSTR_WFI  = 32'h1050_0073;

    logic [2:0]       funct3;
    logic             is_system;
    logic             is_csr;
    logic             known_addr;
    logic             writes;
    logic             read_only;
    logic             bad_enc;
    csr_pkg::csr_op_e op;

    assign funct3     = instr_i[14:12];
    assign csr_addr_o = instr_i[31:20];
    assign zimm_o     = instr_i[19:15];
    assign use_imm_o  = funct3[2];
    assign is_system  = instr_valid_i && (instr_i[6:0] == OPC_SYSTEM);
    assign is_csr     = funct3[1:0] != 2'b00;

    always_comb begin
        op      = csr_pkg::CSR_OP_NONE;
        bad_enc = 1'b0;
        case (funct3)
            3'b001: op = csr_pkg::CSR_OP_RW;
            3'b010: op = csr_pkg::CSR_OP_RS;
            3'b011: op = csr_pkg::CSR_OP_RC;
            3'b101: op = csr_pkg::CSR_OP_RWI;
            3'b110: op = csr_pkg::CSR_OP_RSI;
            3'b111: op = csr_pkg::CSR_OP_RCI;
            3'b000: begin
                if (instr_i == INSTR_MRET) begin
                    op = csr_pkg::CSR_OP_MRET;
                end else if (instr_i == INSTR_WFI) begin
                    op = csr_pkg::CSR_OP_WFI;
                end else begin
                    bad_enc = 1'b1;
                end
            end
            default: bad_enc = 1'b1;
        endcase
    end

    always_comb begin
        case (csr_addr_o)
            csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MIE, csr_pkg::ADDR_MTVEC,
            csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MIP,
            csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_MINSTRET,
            csr_pkg::ADDR_MCYCLEH, csr_pkg::ADDR_MINSTRETH: known_addr = 1'b1;
            default: known_addr = 1'b0;
        endcase
    end

    // rw always writes, set/clear only with a nonzero rs1 field
    assign writes = (funct3[1:0] == 2'b01) || (instr_i[19:15] != 5'd0);

    // counter writes are not supported, so the counters count as read-only too
    assign read_only = (csr_addr_o[11:10] == 2'b11) ||
                       (csr_addr_o == csr_pkg::ADDR_MCYCLE) ||
                       (csr_addr_o == csr_pkg::ADDR_MINSTRET) ||
                       (csr_addr_o == csr_pkg::ADDR_MCYCLEH) ||
                       (csr_addr_o == csr_pkg::ADDR_MINSTRETH);

    assign illegal_o = is_system &&
                       (bad_enc || (is_csr && (!known_addr || (writes && read_only))));
    assign op_o      = is_system ? op : csr_pkg::CSR_OP_NONE;

endmodule

//--- rtl/irq_sync.sv
`timescale 1ns/1ps

module irq_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic irq_i,
    output logic irq_sync_o
);

    logic [SYNC_STAGES-1:0] sync_q;

    // fewer than two flops gives no metastability margin
    if (SYNC_STAGES < 2) begin : g_stage_check
        $fatal(1, "irq_sync: SYNC_STAGES must be at least 2");
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], irq_i};
        end
    end

    assign irq_sync_o = sync_q[SYNC_STAGES-1];

endmodule

//--- rtl/hpm_counters.sv
`timescale 1ns/1ps

module hpm_counters (
    input  logic               clk,
    input  logic               rst,
    input  logic               retire_i,
    input  csr_pkg::csr_addr_t csr_addr_i,
    output csr_pkg::word_t     cnt_rdata_o,
    output logic               cnt_hit_o
);

    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcycle_q   <= 64'd0;
            minstret_q <= 64'd0;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
            if (retire_i) begin
                minstret_q <= minstret_q + 64'd1;
            end
        end
    end

    // read port returns one half at a time
    always_comb begin
        cnt_hit_o   = 1'b1;
        cnt_rdata_o = '0;
        case (csr_addr_i)
            csr_pkg::ADDR_MCYCLE:    cnt_rdata_o = mcycle_q[31:0];
            csr_pkg::ADDR_MCYCLEH:   cnt_rdata_o = mcycle_q[63:32];
            csr_pkg::ADDR_MINSTRET:  cnt_rdata_o = minstret_q[31:0];
            csr_pkg::ADDR_MINSTRETH: cnt_rdata_o = minstret_q[63:32];
            default:                 cnt_hit_o   = 1'b0;
        endcase
    end

endmodule

//--- rtl/machine_csr.sv
`timescale 1ns/1ps

module machine_csr #(
    parameter csr_pkg::word_t RESET_MTVEC = 32'h0000_1000
) (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_op_e   op_i,
    input  csr_pkg::csr_addr_t csr_addr_i,
    input  logic               use_imm_i,
    input  logic [4:0]         zimm_i,
    input  logic               illegal_i,
    input  csr_pkg::word_t     rs1_rdata_i,
    input  csr_pkg::word_t     pc_i,
    input  logic               meip_i,
    output csr_pkg::word_t     csr_rdata_o,
    output logic               redirect_o,
    output csr_pkg::word_t     redirect_pc_o,
    output logic               stall_o
);

    csr_pkg::word_t mstatus_q;
    csr_pkg::word_t mie_q;
    csr_pkg::word_t mtvec_q;
    csr_pkg::word_t mepc_q;
    csr_pkg::word_t mip;
    csr_pkg::word_t operand;
    csr_pkg::word_t wdata;
    logic           accept;
    logic           irq_take;
    logic           active;
    logic           is_rw;
    logic           csr_go;
    logic           wr_en;
    logic           wfi_go;
    logic           mret_go;

    always_comb begin
        mip                    = '0;
        mip[csr_pkg::BIT_MEIP] = meip_i;
    end

    always_comb begin
        case (csr_addr_i)
            csr_pkg::ADDR_MSTATUS: csr_rdata_o = mstatus_q;
            csr_pkg::ADDR_MIE:     csr_rdata_o = mie_q;
            csr_pkg::ADDR_MTVEC:   csr_rdata_o = mtvec_q;
            csr_pkg::ADDR_MEPC:    csr_rdata_o = mepc_q;
            csr_pkg::ADDR_MIP:     csr_rdata_o = mip;
            default:               csr_rdata_o = '0;
        endcase
    end

    // every SYSTEM instruction is accepted including illegal ones
    assign accept   = (op_i != csr_pkg::CSR_OP_NONE) || illegal_i;
    assign irq_take = accept && mstatus_q[csr_pkg::BIT_MIE] &&
                      mie_q[csr_pkg::BIT_MEIE] && meip_i;
    assign active   = accept && !stall_o && !irq_take;

    assign wfi_go   = active && (op_i == csr_pkg::CSR_OP_WFI) && mie_q[csr_pkg::BIT_MEIE];
    assign mret_go  = active && (op_i == csr_pkg::CSR_OP_MRET);

    assign is_rw    = (op_i == csr_pkg::CSR_OP_RW) || (op_i == csr_pkg::CSR_OP_RWI);
    assign csr_go   = active && !illegal_i && (op_i inside {
                          csr_pkg::CSR_OP_RW, csr_pkg::CSR_OP_RS, csr_pkg::CSR_OP_RC,
                          csr_pkg::CSR_OP_RWI, csr_pkg::CSR_OP_RSI, csr_pkg::CSR_OP_RCI});

    assign operand  = use_imm_i ? {27'd0, zimm_i} : rs1_rdata_i;

    always_comb begin
        case (op_i)
            csr_pkg::CSR_OP_RS, csr_pkg::CSR_OP_RSI: wdata = csr_rdata_o | operand;
            csr_pkg::CSR_OP_RC, csr_pkg::CSR_OP_RCI: wdata = csr_rdata_o & ~operand;
            default:                                 wdata = operand;
        endcase
    end

    // set/clear with a zero operand leaves the csr alone
    assign wr_en = csr_go && (is_rw || (operand != '0));

    assign redirect_o    = irq_take || mret_go;
    assign redirect_pc_o = irq_take ? {mtvec_q[31:2], 2'b00} : mepc_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= RESET_MTVEC;
            mepc_q    <= '0;
        end else if (irq_take) begin
            mepc_q                              <= {pc_i[31:2], 2'b00};
            mstatus_q[csr_pkg::BIT_MPIE]        <= mstatus_q[csr_pkg::BIT_MIE];
            mstatus_q[csr_pkg::BIT_MIE]         <= 1'b0;
            mstatus_q[csr_pkg::BIT_MPP_LO +: 2] <= 2'b11;
        end else if (wfi_go) begin
            // resume after the wfi
            mepc_q <= {pc_i[31:2] + 30'd1, 2'b00};
        end else if (mret_go) begin
            mstatus_q[csr_pkg::BIT_MIE]         <= mstatus_q[csr_pkg::BIT_MPIE];
            mstatus_q[csr_pkg::BIT_MPIE]        <= 1'b1;
            mstatus_q[csr_pkg::BIT_MPP_LO +: 2] <= 2'b11;
        end else if (wr_en) begin
            case (csr_addr_i)
                csr_pkg::ADDR_MSTATUS: begin
                    mstatus_q[csr_pkg::BIT_MIE]         <= wdata[csr_pkg::BIT_MIE];
                    mstatus_q[csr_pkg::BIT_MPIE]        <= wdata[csr_pkg::BIT_MPIE];
                    mstatus_q[csr_pkg::BIT_MPP_LO +: 2] <= wdata[csr_pkg::BIT_MPP_LO +: 2];
                end
                csr_pkg::ADDR_MIE:   mie_q[csr_pkg::BIT_MEIE] <= wdata[csr_pkg::BIT_MEIE];
                csr_pkg::ADDR_MTVEC: mtvec_q[31:2] <= wdata[31:2];
                csr_pkg::ADDR_MEPC:  mepc_q[31:2] <= wdata[31:2];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stall_o <= 1'b0;
        end else if (irq_take) begin
            stall_o <= 1'b0;
        end else if (wfi_go) begin
            stall_o <= 1'b1;
        end
    end

    // a redirect never hands over to a wfi sleep
    a_no_stall_after_redirect: assert property (
        @(posedge clk) disable iff (rst) redirect_o |=> !$rose(stall_o));

    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst) redirect_o |-> (redirect_pc_o[1:0] == 2'b00));

    // only an interrupt wakes the core
    a_wake_by_irq: assert property (
        @(posedge clk) disable iff (rst) $fell(stall_o) |-> $past(irq_take));

endmodule

//--- rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
    parameter csr_pkg::word_t RESET_MTVEC = 32'h0000_1000,
    parameter int             SYNC_STAGES = 2
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid_i,
    input  csr_pkg::word_t instr_i,
    input  csr_pkg::word_t pc_i,
    input  csr_pkg::word_t rs1_rdata_i,
    input  logic           retire_i,
    input  logic           irq_i,
    output csr_pkg::word_t rd_rdata_o,
    output logic           illegal_o,
    output logic           redirect_o,
    output csr_pkg::word_t redirect_pc_o,
    output logic           stall_o
);

    csr_pkg::csr_op_e   op;
    csr_pkg::csr_addr_t csr_addr;
    logic               use_imm;
    logic [4:0]         zimm;
    logic               illegal;
    logic               irq_sync;
    csr_pkg::word_t     cnt_rdata;
    logic               cnt_hit;
    csr_pkg::word_t     csr_rdata;

    csr_decode u_decode (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .op_o          (op),
        .csr_addr_o    (csr_addr),
        .use_imm_o     (use_imm),
        .zimm_o        (zimm),
        .illegal_o     (illegal)
    );

    irq_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_irq_sync (
        .clk        (clk),
        .rst        (rst),
        .irq_i      (irq_i),
        .irq_sync_o (irq_sync)
    );

    hpm_counters u_counters (
        .clk         (clk),
        .rst         (rst),
        .retire_i    (retire_i),
        .csr_addr_i  (csr_addr),
        .cnt_rdata_o (cnt_rdata),
        .cnt_hit_o   (cnt_hit)
    );

    machine_csr #(
        .RESET_MTVEC (RESET_MTVEC)
    ) u_machine_csr (
        .clk           (clk),
        .rst           (rst),
        .op_i          (op),
        .csr_addr_i    (csr_addr),
        .use_imm_i     (use_imm),
        .zimm_i        (zimm),
        .illegal_i     (illegal),
        .rs1_rdata_i   (rs1_rdata_i),
        .pc_i          (pc_i),
        .meip_i        (irq_sync),
        .csr_rdata_o   (csr_rdata),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .stall_o       (stall_o)
    );

    // counters live in their own block
    assign rd_rdata_o = cnt_hit ? cnt_rdata : csr_rdata;
    assign illegal_o  = illegal;

endmodule

//--- testbench/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;

    typedef struct packed {
        logic [3:0]     kind;
        csr_pkg::word_t instr;
        csr_pkg::word_t pc;
        csr_pkg::word_t rs1;
        logic           irq;
        logic           retire;
        csr_pkg::word_t rdata;
        logic           redirect;
        csr_pkg::word_t redirect_pc;
        logic           stall;
        logic           illegal;
    } case_t;

    logic           clk = 1'b0;
    logic           rst;
    logic           instr_valid_i;
    csr_pkg::word_t instr_i;
    csr_pkg::word_t pc_i;
    csr_pkg::word_t rs1_rdata_i;
    logic           retire_i;
    logic           irq_i;
    csr_pkg::word_t rd_rdata_o;
    logic           illegal_o;
    logic           redirect_o;
    csr_pkg::word_t redirect_pc_o;
    logic           stall_o;

    case_t          cases[$];
    int             n_cases = 0;
    int             case_idx = 0;
    csr_pkg::word_t cnt_base = '0;

    always #5 clk = ~clk;

    csr_unit dut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_rdata_i   (rs1_rdata_i),
        .retire_i      (retire_i),
        .irq_i         (irq_i),
        .rd_rdata_o    (rd_rdata_o),
        .illegal_o     (illegal_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .stall_o       (stall_o)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input csr_pkg::word_t got,
                              input csr_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%08h, expected 0x%08h (case %0d)",
                               name, got, exp, case_idx));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%h, expected 0x%h (case %0d)",
                               name, got, exp, case_idx));
        end
    endtask

    task automatic load_cases();
        int             fd;
        int             kind;
        string          line;
        csr_pkg::word_t instr;
        csr_pkg::word_t pc;
        csr_pkg::word_t rs1;
        csr_pkg::word_t rdata;
        csr_pkg::word_t rpc;
        logic           irq;
        logic           retire;
        logic           redir;
        logic           stall;
        logic           ill;
        case_t          c;
        fd = $fopen("testbench/csr_cases.txt", "r");
        if (fd == 0) begin
            fail_run("could not open testbench/csr_cases.txt");
        end
        while ($fgets(line, fd) > 0) begin
            // blank lines and comments
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if ($sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", kind, instr, pc, rs1,
                        irq, retire, rdata, redir, rpc, stall, ill) != 11) begin
                fail_run($sformatf("malformed line in case file: %s", line));
            end
            c.kind        = kind[3:0];
            c.instr       = instr;
            c.pc          = pc;
            c.rs1         = rs1;
            c.irq         = irq;
            c.retire      = retire;
            c.rdata       = rdata;
            c.redirect    = redir;
            c.redirect_pc = rpc;
            c.stall       = stall;
            c.illegal     = ill;
            cases.push_back(c);
        end
        $fclose(fd);
    endtask

    task automatic check_case(input case_t c);
        case (c.kind)
            4'd0: check_word("rd_rdata_o", rd_rdata_o, c.rdata);
            4'd1: ;
            // counter snapshot for a later difference
            4'd2: cnt_base = rd_rdata_o;
            4'd3: check_word("rd_rdata_o delta", rd_rdata_o - cnt_base, c.rdata);
            default: fail_run($sformatf("unknown check kind %0d in case %0d",
                                        c.kind, case_idx));
        endcase
        check_flag("redirect_o", redirect_o, c.redirect);
        if (c.redirect) begin
            check_word("redirect_pc_o", redirect_pc_o, c.redirect_pc);
        end
        check_flag("stall_o", stall_o, c.stall);
        check_flag("illegal_o", illegal_o, c.illegal);
    endtask

    initial begin
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rs1_rdata_i   = '0;
        retire_i      = 1'b0;
        irq_i         = 1'b0;
        load_cases();
        n_cases = cases.size();
        if (n_cases == 0) begin
            fail_run("no cases found in testbench/csr_cases.txt");
        end
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        foreach (cases[i]) begin
            case_idx = i;
            @(posedge clk);
            #1;
            // an all-zero word stands for an idle cycle
            instr_valid_i = (cases[i].instr != '0);
            instr_i       = cases[i].instr;
            pc_i          = cases[i].pc;
            rs1_rdata_i   = cases[i].rs1;
            irq_i         = cases[i].irq;
            retire_i      = cases[i].retire;
            #8;
            check_case(cases[i]);
        end
        $display("Simulation PASSED");
        $finish;
    end

    // watchdog sized from the case count
    initial begin
        wait (n_cases != 0);
        #((n_cases + 50) * 10);
        fail_run("timeout, the run did not finish in time");
    end

endmodule

//--- csr_unit.f
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/irq_sync.sv
rtl/hpm_counters.sv
rtl/machine_csr.sv
rtl/csr_unit.sv
testbench/tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f csr_unit.f --top-module tb_csr_unit -o tb_csr_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_csr_unit 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- testbench/csr_cases.txt
# kind: 0 check all, 1 flags only, 2 store rdata as counter base, 3 rdata minus base
# kind instr pc rs1 irq retire rdata redirect redirect_pc stall illegal
0 300020F3 00000000 00000000 0 0 00000000 0 00000000 0 0
0 304020F3 00000000 00000000 0 0 00000000 0 00000000 0 0
0 305020F3 00000000 00000000 0 0 00001000 0 00000000 0 0
0 341020F3 00000000 00000000 0 0 00000000 0 00000000 0 0
0 305110F3 00000000 00002003 0 0 00001000 0 00000000 0 0
0 305020F3 00000000 00000000 0 0 00002000 0 00000000 0 0
0 341110F3 00000000 00000457 0 0 00000000 0 00000000 0 0
0 341130F3 00000000 00000050 0 0 00000454 0 00000000 0 0
0 341020F3 00000000 00000000 0 0 00000404 0 00000000 0 0
0 300120F3 00000000 FFFFFFFF 0 0 00000000 0 00000000 0 0
0 300470F3 00000000 00000000 0 0 00001888 0 00000000 0 0
0 300130F3 00000000 00001800 0 0 00001880 0 00000000 0 0
0 300020F3 00000000 00000000 0 0 00000080 0 00000000 0 0
0 304060F3 00000000 00000000 0 0 00000000 0 00000000 0 0
0 304120F3 00000000 FFFFFFFF 0 0 00000000 0 00000000 0 0
0 304020F3 00000000 00000000 0 0 00000800 0 00000000 0 0
0 7C0020F3 00000000 00000000 0 0 00000000 0 00000000 0 1
1 B00110F3 00000000 00001234 0 0 00000000 0 00000000 0 1
0 300040F3 00000000 00000000 0 0 00000080 0 00000000 0 1
0 300020F3 00000000 00000000 0 0 00000080 0 00000000 0 0
2 B00020F3 00000000 00000000 0 1 00000000 0 00000000 0 0
1 00000000 00000000 00000000 0 1 00000000 0 00000000 0 0
1 00000000 00000000 00000000 0 0 00000000 0 00000000 0 0
3 B00020F3 00000000 00000000 0 0 00000003 0 00000000 0 0
2 B02020F3 00000000 00000000 0 1 00000000 0 00000000 0 0
1 00000000 00000000 00000000 0 1 00000000 0 00000000 0 0
1 00000000 00000000 00000000 0 0 00000000 0 00000000 0 0
1 00000000 00000000 00000000 0 1 00000000 0 00000000 0 0
3 B02020F3 00000000 00000000 0 0 00000003 0 00000000 0 0
0 300460F3 00000000 00000000 0 0 00000080 0 00000000 0 0
1 00000000 00000000 00000000 1 0 00000000 0 00000000 0 0
1 00000000 00000000 00000000 1 0 00000000 0 00000000 0 0
0 304020F3 00000300 00000000 1 0 00000800 1 00002000 0 0
0 344020F3 00000000 00000000 0 0 00000800 0 00000000 0 0
0 341020F3 00000000 00000000 0 0 00000300 0 00000000 0 0
0 300020F3 00000000 00000000 0 0 00001880 0 00000000 0 0
0 30200073 00000000 00000000 0 0 00000000 1 00000300 0 0
0 300020F3 00000000 00000000 0 0 00001888 0 00000000 0 0
0 10500073 00000500 00000000 0 0 00000000 0 00000000 0 0
0 305110F3 00000000 00003000 0 0 00002000 0 00000000 1 0
0 305020F3 00000000 00000000 0 0 00002000 0 00000000 1 0
1 00000000 00000000 00000000 1 0 00000000 0 00000000 1 0
1 00000000 00000000 00000000 1 0 00000000 0 00000000 1 0
0 341020F3 00000600 00000000 1 0 00000504 1 00002000 1 0
0 341020F3 00000000 00000000 0 0 00000600 0 00000000 0 0
0 300020F3 00000000 00000000 0 0 00001880 0 00000000 0 0
